//--- hw/f8_isa_pkg.sv
// instruction set of the reduced f8 core
// opcodes, flag layout, the two views of an instruction word and the size table
// used by the sequencer, the execute unit and the testbench reference model
package f8_isa_pkg;

	localparam int INST_W = 24;

	typedef enum logic [7:0]
	{
		OP_NOP = 8'h00,
		OP_TRAP = 8'h01,
		OP_LD_XL_IMM = 8'h10,
		OP_ADD_XL_IMM = 8'h11,
		OP_SUB_XL_IMM = 8'h12,
		OP_AND_XL_IMM = 8'h13,
		OP_OR_XL_IMM = 8'h14,
		OP_XOR_XL_IMM = 8'h15,
		OP_LD_XL_DIR = 8'h20,
		OP_LD_DIR_XL = 8'h21,
		OP_LDW_Y_IMM = 8'h22,
		OP_LDW_DIR_Y = 8'h23,
		OP_JR_D = 8'h30,
		OP_JRZ_D = 8'h31,
		OP_JRNZ_D = 8'h32,
		OP_JRC_D = 8'h33,
		OP_JP_IMM = 8'h34
	} opcode_t;

	typedef struct packed
	{
		logic [2:0] rsvd;
		logic o;
		logic z;
		logic n;
		logic c;
		logic h;
	} flag_t;

	// opcode with a 16-bit address or immediate above it
	typedef struct packed
	{
		logic [INST_W-9:0] addr;
		opcode_t opcode;
	} inst_abs_t;

	// opcode with a signed displacement or 8-bit immediate
	typedef struct packed
	{
		logic [INST_W-17:0] unused;
		logic signed [7:0] disp;
		opcode_t opcode;
	} inst_rel_t;

	typedef union packed
	{
		inst_abs_t abs;
		inst_rel_t rel;
	} inst_t;

	typedef struct packed
	{
		logic taken;
		logic [15:0] target;
	} branch_t;

	function automatic logic [1:0] inst_size(opcode_t op);
		case (op)
			OP_LD_XL_IMM, OP_ADD_XL_IMM, OP_SUB_XL_IMM, OP_AND_XL_IMM, OP_OR_XL_IMM,
			OP_XOR_XL_IMM, OP_JR_D, OP_JRZ_D, OP_JRNZ_D, OP_JRC_D:
				return 2'd2;
			OP_LD_XL_DIR, OP_LD_DIR_XL, OP_LDW_Y_IMM, OP_LDW_DIR_Y, OP_JP_IMM:
				return 2'd3;
			default:
				return 2'd1;
		endcase
	endfunction

endpackage

//--- hw/f8_bus_pkg.sv
// memory side of the f8 core
// address widths, reset vector, read and write requests and the bank port
package f8_bus_pkg;

	localparam int ADDR_W = 16;
	localparam int BANK_ADDR_W = 15;

	localparam logic [ADDR_W-1:0] RESET_PC = 16'h4000;

	typedef struct packed
	{
		logic valid;
		logic [ADDR_W-1:0] addr;
	} rd_req_t;

	// little endian, low byte goes to addr and high byte to addr + 1
	typedef struct packed
	{
		logic be_hi;
		logic be_lo;
		logic [ADDR_W-1:0] addr;
		logic [15:0] data;
	} wr_req_t;

	typedef struct packed
	{
		logic [BANK_ADDR_W-1:0] rd_addr;
		logic [BANK_ADDR_W-1:0] wr_addr;
		logic [7:0] wr_data;
		logic wr_en;
	} bank_port_t;

endpackage

//--- hw/f8_regfile.sv
// general registers x, y, z with per-byte write enables, plus the flag register
// written by the execute unit at the end of the execute cycle
`timescale 1ns/1ps

module f8_regfile
(
	input logic clk,
	input logic reset,
	input logic [1:0] wr_addr,
	input logic [1:0] wr_en,
	input logic [15:0] wr_data,
	input f8_isa_pkg::flag_t next_flags,
	output logic [15:0] x,
	output logic [15:0] y,
	output logic [15:0] z,
	output f8_isa_pkg::flag_t flags
);

	logic [15:0] regs [3];

	assign x = regs[0];
	assign y = regs[1];
	assign z = regs[2];

	always_ff @(posedge clk)
	begin
		if (wr_en[0])
			regs[wr_addr][7:0] <= wr_data[7:0];
		if (wr_en[1])
			regs[wr_addr][15:8] <= wr_data[15:8];
	end

	always_ff @(posedge clk)
	begin
		if (reset)
			flags <= '0;
		else
			flags <= next_flags;
	end

	// only three registers exist
	assert property (@(posedge clk) disable iff (reset)
		(wr_en != 2'b00) |-> (wr_addr != 2'd3));

endmodule

//--- hw/f8_sequencer.sv
// instruction fetch and program counter
// builds the current instruction from the fetched word, the held low bytes plus
// an upper byte, or the held word while a memory operand is read
`timescale 1ns/1ps

module f8_sequencer
(
	input logic clk,
	input logic reset,
	input logic [15:0] rd_word,
	input f8_isa_pkg::branch_t branch,
	output f8_bus_pkg::rd_req_t fetch_req,
	output f8_bus_pkg::rd_req_t upper_req,
	output f8_isa_pkg::inst_t inst,
	output logic execute,
	output logic [f8_bus_pkg::ADDR_W-1:0] pc,
	output logic trap
);

	logic fetch_valid;
	logic upper_pend;
	logic op_pend;
	f8_isa_pkg::inst_t held;
	f8_isa_pkg::opcode_t opcode;
	logic upper_load;
	logic operand_load;
	logic [f8_bus_pkg::ADDR_W-1:0] next_pc;

	always_comb
	begin
		// first cycle out of reset has no fetched word yet
		if (!fetch_valid)
		begin
			inst = '0;
			inst.abs.opcode = f8_isa_pkg::OP_NOP;
		end
		else if (upper_pend)
			inst = f8_isa_pkg::inst_t'({rd_word[7:0], held.abs.addr[7:0], held.abs.opcode});
		else if (op_pend)
			inst = held;
		else
			inst = f8_isa_pkg::inst_t'({8'h00, rd_word});
	end

	assign opcode = inst.abs.opcode;

	assign upper_load = fetch_valid && !upper_pend && !op_pend &&
		(f8_isa_pkg::inst_size(opcode) == 2'd3);
	assign operand_load = upper_pend && (opcode == f8_isa_pkg::OP_LD_XL_DIR);

	// execute decoded from the fetch state, nothing runs while in reset
	assign execute = fetch_valid && !reset &&
		(op_pend || (upper_pend ? (opcode != f8_isa_pkg::OP_LD_XL_DIR) :
		(f8_isa_pkg::inst_size(opcode) != 2'd3)));
	assign trap = execute && (opcode == f8_isa_pkg::OP_TRAP);

	always_comb
	begin
		if (!execute || trap)
			next_pc = pc;
		else if (branch.taken)
			next_pc = branch.target;
		else
			next_pc = pc + 16'(f8_isa_pkg::inst_size(opcode));
	end

	assign fetch_req = '{valid: !upper_load && !operand_load, addr: next_pc};
	assign upper_req = '{valid: upper_load, addr: pc + 16'd2};

	always_ff @(posedge clk)
	begin
		held <= inst;
		if (reset)
		begin
			pc <= f8_bus_pkg::RESET_PC;
			fetch_valid <= 1'b0;
			upper_pend <= 1'b0;
			op_pend <= 1'b0;
		end
		else
		begin
			pc <= next_pc;
			fetch_valid <= 1'b1;
			upper_pend <= upper_load;
			op_pend <= operand_load;
		end
	end

	// no instruction executes in an upper byte stall
	assert property (@(posedge clk) disable iff (reset)
		upper_req.valid |-> !execute);

endmodule

//--- hw/f8_execute.sv
// execute stage, purely combinational
// 8-bit ALU and flags, operand request for direct loads, register and
// memory writes, and the branch decision handed back to the sequencer
`timescale 1ns/1ps

module f8_execute
(
	input logic execute,
	input f8_isa_pkg::inst_t inst,
	input logic [15:0] pc,
	input logic [15:0] rd_word,
	input logic [15:0] x,
	input logic [15:0] y,
	input f8_isa_pkg::flag_t flags,
	output f8_bus_pkg::rd_req_t operand_req,
	output f8_bus_pkg::wr_req_t wr_req,
	output logic [1:0] reg_wr_addr,
	output logic [1:0] reg_wr_en,
	output logic [15:0] reg_wr_data,
	output f8_isa_pkg::flag_t next_flags,
	output f8_isa_pkg::branch_t branch
);

	f8_isa_pkg::opcode_t opcode;
	logic [7:0] acc;
	logic [7:0] imm;
	logic [7:0] opb;
	logic sub;
	logic [8:0] sum;
	logic [4:0] half;
	logic [7:0] byte_res;
	logic [15:0] rel_target;

	assign opcode = inst.abs.opcode;
	assign acc = x[7:0];
	assign imm = inst.rel.disp;

	// subtract is acc + ~imm + 1 on the same adder
	assign sub = (opcode == f8_isa_pkg::OP_SUB_XL_IMM);
	assign opb = sub ? ~imm : imm;
	assign sum = {1'b0, acc} + {1'b0, opb} + 9'(sub);
	assign half = {1'b0, acc[3:0]} + {1'b0, opb[3:0]} + 5'(sub);

	always_comb
	begin
		case (opcode)
			f8_isa_pkg::OP_LD_XL_DIR: byte_res = rd_word[7:0];
			f8_isa_pkg::OP_AND_XL_IMM: byte_res = acc & imm;
			f8_isa_pkg::OP_OR_XL_IMM: byte_res = acc | imm;
			f8_isa_pkg::OP_XOR_XL_IMM: byte_res = acc ^ imm;
			default: byte_res = imm;
		endcase
	end

	// direct load address goes out while the sequencer holds the word
	assign operand_req = '{valid: !execute && (opcode == f8_isa_pkg::OP_LD_XL_DIR),
		addr: inst.abs.addr};

	assign rel_target = pc + 16'(f8_isa_pkg::inst_size(opcode)) +
		{{8{inst.rel.disp[7]}}, inst.rel.disp};

	always_comb
	begin
		wr_req = '0;
		reg_wr_addr = 2'd0;
		reg_wr_en = 2'b00;
		reg_wr_data = {8'h00, byte_res};
		next_flags = flags;
		next_flags.rsvd = 3'b000;
		branch.taken = 1'b0;
		branch.target = rel_target;
		if (execute)
		begin
			case (opcode)
				f8_isa_pkg::OP_LD_XL_IMM, f8_isa_pkg::OP_LD_XL_DIR, f8_isa_pkg::OP_AND_XL_IMM,
				f8_isa_pkg::OP_OR_XL_IMM, f8_isa_pkg::OP_XOR_XL_IMM:
				begin
					reg_wr_en = 2'b01;
					next_flags.z = (byte_res == 8'h00);
					next_flags.n = byte_res[7];
				end
				f8_isa_pkg::OP_ADD_XL_IMM, f8_isa_pkg::OP_SUB_XL_IMM:
				begin
					reg_wr_en = 2'b01;
					reg_wr_data = {8'h00, sum[7:0]};
					next_flags.o = (acc[7] == opb[7]) && (sum[7] != acc[7]);
					next_flags.z = (sum[7:0] == 8'h00);
					next_flags.n = sum[7];
					next_flags.c = sum[8];
					next_flags.h = half[4];
				end
				f8_isa_pkg::OP_LDW_Y_IMM:
				begin
					reg_wr_addr = 2'd1;
					reg_wr_en = 2'b11;
					reg_wr_data = inst.abs.addr;
				end
				f8_isa_pkg::OP_LD_DIR_XL:
				begin
					wr_req.be_lo = 1'b1;
					wr_req.addr = inst.abs.addr;
					wr_req.data = {8'h00, acc};
				end
				f8_isa_pkg::OP_LDW_DIR_Y:
				begin
					wr_req.be_lo = 1'b1;
					wr_req.be_hi = 1'b1;
					wr_req.addr = inst.abs.addr;
					wr_req.data = y;
				end
				f8_isa_pkg::OP_JR_D: branch.taken = 1'b1;
				f8_isa_pkg::OP_JRZ_D: branch.taken = flags.z;
				f8_isa_pkg::OP_JRNZ_D: branch.taken = !flags.z;
				f8_isa_pkg::OP_JRC_D: branch.taken = flags.c;
				f8_isa_pkg::OP_JP_IMM:
				begin
					branch.taken = 1'b1;
					branch.target = inst.abs.addr;
				end
				default:
				begin
				end
			endcase
		end
	end

endmodule

//--- hw/f8_bus_arbiter.sv
// shares the single read path between upper byte, operand and fetch requests
// and maps byte accesses onto the even and odd banks
// returned bytes are swapped back by the parity of the previous read address
`timescale 1ns/1ps

module f8_bus_arbiter
(
	input logic clk,
	input logic reset,
	input f8_bus_pkg::rd_req_t fetch_req,
	input f8_bus_pkg::rd_req_t upper_req,
	input f8_bus_pkg::rd_req_t operand_req,
	input f8_bus_pkg::wr_req_t wr_req,
	input logic [7:0] even_rdata,
	input logic [7:0] odd_rdata,
	output f8_bus_pkg::bank_port_t even_port,
	output f8_bus_pkg::bank_port_t odd_port,
	output logic [15:0] rd_word
);

	logic [f8_bus_pkg::ADDR_W-1:0] rd_addr;
	logic [f8_bus_pkg::BANK_ADDR_W-1:0] rd_bank_addr;
	logic [f8_bus_pkg::BANK_ADDR_W-1:0] wr_bank_addr;
	logic rd_odd;

	// fixed priority with fetch as the fallback
	always_comb
	begin
		rd_addr = fetch_req.addr;
		if (upper_req.valid)
			rd_addr = upper_req.addr;
		else if (operand_req.valid)
			rd_addr = operand_req.addr;
	end

	assign rd_bank_addr = rd_addr[f8_bus_pkg::ADDR_W-1:1];
	assign wr_bank_addr = wr_req.addr[f8_bus_pkg::ADDR_W-1:1];

	always_comb
	begin
		even_port.rd_addr = rd_addr[0] ? rd_bank_addr + 1'b1 : rd_bank_addr;
		odd_port.rd_addr = rd_bank_addr;
		even_port.wr_addr = wr_req.addr[0] ? wr_bank_addr + 1'b1 : wr_bank_addr;
		odd_port.wr_addr = wr_bank_addr;
		even_port.wr_data = wr_req.addr[0] ? wr_req.data[15:8] : wr_req.data[7:0];
		odd_port.wr_data = wr_req.addr[0] ? wr_req.data[7:0] : wr_req.data[15:8];
		even_port.wr_en = wr_req.addr[0] ? wr_req.be_hi : wr_req.be_lo;
		odd_port.wr_en = wr_req.addr[0] ? wr_req.be_lo : wr_req.be_hi;
	end

	always_ff @(posedge clk)
	begin
		if (reset)
			rd_odd <= 1'b0;
		else
			rd_odd <= rd_addr[0];
	end

	assign rd_word = rd_odd ? {even_rdata, odd_rdata} : {odd_rdata, even_rdata};

	assert property (@(posedge clk) reset |-> !even_port.wr_en && !odd_port.wr_en);

	// some requester always owns the read port
	assert property (@(posedge clk) disable iff (reset)
		fetch_req.valid || upper_req.valid || operand_req.valid);

endmodule

//--- hw/f8_core.sv
// top of the reduced f8 core
// connects sequencer, execute unit, register file and bank arbiter
`timescale 1ns/1ps

module f8_core
(
	input logic clk,
	input logic reset,
	input logic [7:0] even_rdata,
	input logic [7:0] odd_rdata,
	output f8_bus_pkg::bank_port_t even_port,
	output f8_bus_pkg::bank_port_t odd_port,
	output logic trap
);

	f8_bus_pkg::rd_req_t fetch_req;
	f8_bus_pkg::rd_req_t upper_req;
	f8_bus_pkg::rd_req_t operand_req;
	f8_bus_pkg::wr_req_t wr_req;
	f8_isa_pkg::inst_t inst;
	f8_isa_pkg::branch_t branch;
	f8_isa_pkg::flag_t flags;
	f8_isa_pkg::flag_t next_flags;
	logic execute;
	logic [15:0] pc;
	logic [15:0] rd_word;
	logic [15:0] x;
	logic [15:0] y;
	logic [1:0] reg_wr_addr;
	logic [1:0] reg_wr_en;
	logic [15:0] reg_wr_data;

	f8_sequencer f8_sequencer_inst
	(
		.clk(clk),
		.reset(reset),
		.rd_word(rd_word),
		.branch(branch),
		.fetch_req(fetch_req),
		.upper_req(upper_req),
		.inst(inst),
		.execute(execute),
		.pc(pc),
		.trap(trap)
	);

	f8_execute f8_execute_inst
	(
		.execute(execute),
		.inst(inst),
		.pc(pc),
		.rd_word(rd_word),
		.x(x),
		.y(y),
		.flags(flags),
		.operand_req(operand_req),
		.wr_req(wr_req),
		.reg_wr_addr(reg_wr_addr),
		.reg_wr_en(reg_wr_en),
		.reg_wr_data(reg_wr_data),
		.next_flags(next_flags),
		.branch(branch)
	);

	f8_regfile f8_regfile_inst
	(
		.clk(clk),
		.reset(reset),
		.wr_addr(reg_wr_addr),
		.wr_en(reg_wr_en),
		.wr_data(reg_wr_data),
		.next_flags(next_flags),
		.x(x),
		.y(y),
		.z(),
		.flags(flags)
	);

	f8_bus_arbiter f8_bus_arbiter_inst
	(
		.clk(clk),
		.reset(reset),
		.fetch_req(fetch_req),
		.upper_req(upper_req),
		.operand_req(operand_req),
		.wr_req(wr_req),
		.even_rdata(even_rdata),
		.odd_rdata(odd_rdata),
		.even_port(even_port),
		.odd_port(odd_port),
		.rd_word(rd_word)
	);

endmodule

//--- verif/f8_core_tb.sv
// testbench for the reduced f8 core
// runs a set of small programs from 0x4000, each ending in trap, and checks every
// bank write against an instruction-level model of the same program
`timescale 1ns/1ps

module f8_core_tb;

	typedef struct packed
	{
		logic [15:0] addr;
		logic [7:0] data;
	} mem_write_t;

	logic clk;
	logic reset;
	logic [7:0] even_rdata;
	logic [7:0] odd_rdata;
	f8_bus_pkg::bank_port_t even_port;
	f8_bus_pkg::bank_port_t odd_port;
	logic trap;

	logic [7:0] even_mem [16384];
	logic [7:0] odd_mem [16384];
	logic [7:0] ref_mem [32768];
	logic [7:0] prog [$];
	mem_write_t exp_q [$];
	int prog_insts;
	int exp_count;
	int writes_seen;
	int cycle_count;
	int cycle_limit;
	logic trap_seen;
	logic odd_first;
	logic [15:0] data_ptr;
	integer seed;

	f8_core f8_core_inst
	(
		.clk(clk),
		.reset(reset),
		.even_rdata(even_rdata),
		.odd_rdata(odd_rdata),
		.even_port(even_port),
		.odd_port(odd_port),
		.trap(trap)
	);

	initial
	begin
		clk = 1'b0;
		forever #10 clk = ~clk;
	end

	// synchronous-read banks
	always @(posedge clk)
	begin
		even_rdata <= even_mem[even_port.rd_addr[13:0]];
		odd_rdata <= odd_mem[odd_port.rd_addr[13:0]];
		if (even_port.wr_en)
			even_mem[even_port.wr_addr[13:0]] <= even_port.wr_data;
		if (odd_port.wr_en)
			odd_mem[odd_port.wr_addr[13:0]] <= odd_port.wr_data;
	end

	task automatic report_failure(string msg);
		$display("%s", msg);
		$display("TB FAILED");
		$fatal(1);
	endtask

	task automatic compare_addr(string name, logic [f8_bus_pkg::BANK_ADDR_W-1:0] got,
		logic [f8_bus_pkg::BANK_ADDR_W-1:0] want);
		if (got !== want)
			report_failure($sformatf("Mismatch at %0t: %s got %h expected %h",
				$time, name, got, want));
	endtask

	task automatic compare_byte(string name, logic [7:0] got, logic [7:0] want);
		if (got !== want)
			report_failure($sformatf("Mismatch at %0t: %s got %h expected %h",
				$time, name, got, want));
	endtask

	task automatic compare_count(string name, int got, int want);
		if (got != want)
			report_failure($sformatf("Mismatch at %0t: %s got %0d expected %0d",
				$time, name, got, want));
	endtask

	function automatic logic [7:0] fill_byte(logic [15:0] a);
		return a[7:0] ^ a[15:8] ^ 8'h3c;
	endfunction

	function automatic logic [7:0] ref_byte(logic [15:0] a);
		return ref_mem[a[14:0]];
	endfunction

	function automatic void record_write(logic [15:0] a, logic [7:0] d);
		exp_q.push_back('{addr: a, data: d});
		ref_mem[a[14:0]] = d;
	endfunction

	function automatic logic [15:0] length_of(logic [7:0] op);
		if (op >= 8'h10 && op <= 8'h15)
			return 16'd2;
		if (op >= 8'h30 && op <= 8'h33)
			return 16'd2;
		if ((op >= 8'h20 && op <= 8'h23) || op == 8'h34)
			return 16'd3;
		return 16'd1;
	endfunction

	// instruction-level model, fills exp_q with the byte writes in program order
	function automatic int run_reference();
		logic [15:0] pc;
		logic [15:0] y;
		logic [15:0] operand;
		logic [7:0] op;
		logic [7:0] xl;
		logic [7:0] imm;
		logic [7:0] inv;
		logic [8:0] sum;
		logic [4:0] low_sum;
		logic z, c, n, h, o;
		logic taken;
		int wide;
		int guard;
		exp_q.delete();
		pc = f8_bus_pkg::RESET_PC;
		xl = 8'h00;
		y = 16'h0000;
		{z, c, n, h, o} = 5'b00000;
		guard = 0;
		op = ref_byte(pc);
		while (op != f8_isa_pkg::OP_TRAP && guard < 4096)
		begin
			imm = ref_byte(pc + 16'd1);
			operand = {ref_byte(pc + 16'd2), imm};
			taken = 1'b0;
			case (op)
				f8_isa_pkg::OP_LD_XL_IMM: xl = imm;
				f8_isa_pkg::OP_LD_XL_DIR: xl = ref_byte(operand);
				f8_isa_pkg::OP_AND_XL_IMM: xl = xl & imm;
				f8_isa_pkg::OP_OR_XL_IMM: xl = xl | imm;
				f8_isa_pkg::OP_XOR_XL_IMM: xl = xl ^ imm;
				f8_isa_pkg::OP_ADD_XL_IMM, f8_isa_pkg::OP_SUB_XL_IMM:
				begin
					if (op == f8_isa_pkg::OP_SUB_XL_IMM)
					begin
						inv = ~imm;
						sum = {1'b0, xl} + {1'b0, inv} + 9'd1;
						low_sum = {1'b0, xl[3:0]} + {1'b0, inv[3:0]} + 5'd1;
						wide = $signed(xl) - $signed(imm);
					end
					else
					begin
						sum = {1'b0, xl} + {1'b0, imm};
						low_sum = {1'b0, xl[3:0]} + {1'b0, imm[3:0]};
						wide = $signed(xl) + $signed(imm);
					end
					o = (wide > 127) || (wide < -128);
					c = sum[8];
					h = low_sum[4];
					xl = sum[7:0];
				end
				f8_isa_pkg::OP_LD_DIR_XL: record_write(operand, xl);
				f8_isa_pkg::OP_LDW_Y_IMM: y = operand;
				f8_isa_pkg::OP_LDW_DIR_Y:
				begin
					record_write(operand, y[7:0]);
					record_write(operand + 16'd1, y[15:8]);
				end
				f8_isa_pkg::OP_JR_D: taken = 1'b1;
				f8_isa_pkg::OP_JRZ_D: taken = z;
				f8_isa_pkg::OP_JRNZ_D: taken = !z;
				f8_isa_pkg::OP_JRC_D: taken = c;
				default:
				begin
				end
			endcase
			// every op that writes xl also sets z and n
			if ((op >= 8'h10 && op <= 8'h15) || op == f8_isa_pkg::OP_LD_XL_DIR)
			begin
				z = (xl == 8'h00);
				n = xl[7];
			end
			if (op == f8_isa_pkg::OP_JP_IMM)
				pc = operand;
			else if (taken)
				pc = pc + length_of(op) + {{8{imm[7]}}, imm};
			else
				pc = pc + length_of(op);
			op = ref_byte(pc);
			guard++;
		end
		return exp_q.size();
	endfunction

	task automatic check_write(logic odd_bank, logic [f8_bus_pkg::BANK_ADDR_W-1:0] addr,
		logic [7:0] data);
		mem_write_t want;
		if (exp_q.size() == 0)
			report_failure($sformatf("unexpected write to bank word %h at %0t", addr, $time));
		else
		begin
			want = exp_q.pop_front();
			if (want.addr[0] != odd_bank)
				report_failure($sformatf("write for byte address %h went to the wrong bank",
					want.addr));
			compare_addr(odd_bank ? "odd_port.wr_addr" : "even_port.wr_addr", addr,
				want.addr[15:1]);
			compare_byte(odd_bank ? "odd_port.wr_data" : "even_port.wr_data", data, want.data);
			writes_seen++;
		end
	endtask

	// writes of one cycle are taken in ascending byte address order
	always @(negedge clk)
	begin
		if (reset)
		begin
			if (even_port.wr_en !== 1'b0 || odd_port.wr_en !== 1'b0)
				report_failure("a bank write enable is high during reset");
			if (trap !== 1'b0)
				report_failure("trap is high during reset");
		end
		else
		begin
			odd_first = odd_port.wr_en && even_port.wr_en &&
				(odd_port.wr_addr < even_port.wr_addr);
			if (odd_first)
				check_write(1'b1, odd_port.wr_addr, odd_port.wr_data);
			if (even_port.wr_en)
				check_write(1'b0, even_port.wr_addr, even_port.wr_data);
			if (odd_port.wr_en && !odd_first)
				check_write(1'b1, odd_port.wr_addr, odd_port.wr_data);
			if (trap === 1'b1 && !trap_seen)
			begin
				compare_count("write count", writes_seen, exp_count);
				trap_seen = 1'b1;
			end
			else if (trap_seen && trap !== 1'b1)
				report_failure("trap dropped after it had risen");
		end
	end

	always @(posedge clk)
	begin
		cycle_count++;
		if (cycle_count > cycle_limit)
			report_failure($sformatf("timeout after %0d cycles without trap", cycle_count));
	end

	function automatic logic [15:0] cur_addr();
		return f8_bus_pkg::RESET_PC + 16'(prog.size());
	endfunction

	task automatic emit_one(f8_isa_pkg::opcode_t op);
		prog.push_back(op);
		prog_insts++;
	endtask

	task automatic emit_short(f8_isa_pkg::opcode_t op, logic [7:0] b);
		prog.push_back(op);
		prog.push_back(b);
		prog_insts++;
	endtask

	task automatic emit_long(f8_isa_pkg::opcode_t op, logic [15:0] w);
		prog.push_back(op);
		prog.push_back(w[7:0]);
		prog.push_back(w[15:8]);
		prog_insts++;
	endtask

	// taken and not-taken paths leave different markers in y, then y is stored
	task automatic emit_branch_pair(f8_isa_pkg::opcode_t op, logic [7:0] tag);
		emit_short(op, 8'd5);
		emit_long(f8_isa_pkg::OP_LDW_Y_IMM, {8'h4e, tag});
		emit_short(f8_isa_pkg::OP_JR_D, 8'd3);
		emit_long(f8_isa_pkg::OP_LDW_Y_IMM, {8'h7a, tag});
		emit_long(f8_isa_pkg::OP_LDW_DIR_Y, data_ptr);
		data_ptr = data_ptr + 16'd3;
	endtask

	task automatic build_alu_program();
		f8_isa_pkg::opcode_t ops [9];
		logic [7:0] a [9];
		logic [7:0] b [9];
		ops = '{f8_isa_pkg::OP_ADD_XL_IMM, f8_isa_pkg::OP_ADD_XL_IMM, f8_isa_pkg::OP_ADD_XL_IMM,
			f8_isa_pkg::OP_SUB_XL_IMM, f8_isa_pkg::OP_SUB_XL_IMM, f8_isa_pkg::OP_SUB_XL_IMM,
			f8_isa_pkg::OP_AND_XL_IMM, f8_isa_pkg::OP_OR_XL_IMM, f8_isa_pkg::OP_XOR_XL_IMM};
		a = '{8'h01, 8'hff, 8'h7f, 8'h05, 8'h03, 8'h80, 8'hf0, 8'h00, 8'haa};
		b = '{8'h02, 8'h01, 8'h01, 8'h05, 8'h05, 8'h01, 8'h0f, 8'h00, 8'h55};
		data_ptr = 16'h1000;
		for (int k = 0; k < 9; k++)
		begin
			emit_short(f8_isa_pkg::OP_LD_XL_IMM, a[k]);
			emit_short(ops[k], b[k]);
			emit_long(f8_isa_pkg::OP_LD_DIR_XL, data_ptr);
			data_ptr = data_ptr + 16'd2;
			emit_branch_pair(f8_isa_pkg::OP_JRZ_D, {4'(k), 4'h1});
			emit_branch_pair(f8_isa_pkg::OP_JRNZ_D, {4'(k), 4'h2});
			emit_branch_pair(f8_isa_pkg::OP_JRC_D, {4'(k), 4'h3});
		end
		emit_one(f8_isa_pkg::OP_TRAP);
	endtask

	task automatic build_memory_program();
		emit_long(f8_isa_pkg::OP_LDW_Y_IMM, 16'hbeef);
		emit_long(f8_isa_pkg::OP_LDW_DIR_Y, 16'h1101);
		emit_long(f8_isa_pkg::OP_LDW_Y_IMM, 16'h1234);
		emit_long(f8_isa_pkg::OP_LDW_DIR_Y, 16'h1200);
		// odd then even operand reads from the fill pattern
		emit_long(f8_isa_pkg::OP_LD_XL_DIR, 16'h1301);
		emit_long(f8_isa_pkg::OP_LD_DIR_XL, 16'h1400);
		emit_long(f8_isa_pkg::OP_LD_XL_DIR, 16'h1302);
		emit_long(f8_isa_pkg::OP_LD_DIR_XL, 16'h1402);
		// read back the word written to the odd address
		emit_long(f8_isa_pkg::OP_LD_XL_DIR, 16'h1101);
		emit_long(f8_isa_pkg::OP_LD_DIR_XL, 16'h1404);
		emit_long(f8_isa_pkg::OP_LD_XL_DIR, 16'h1102);
		emit_long(f8_isa_pkg::OP_LD_DIR_XL, 16'h1405);
		emit_one(f8_isa_pkg::OP_TRAP);
	endtask

	task automatic build_jump_program();
		logic [15:0] back_to;
		emit_short(f8_isa_pkg::OP_LD_XL_IMM, 8'h11);
		emit_short(f8_isa_pkg::OP_JR_D, 8'd3);
		emit_long(f8_isa_pkg::OP_LD_DIR_XL, 16'h1500);
		// JP lands on the store after the first trap
		emit_long(f8_isa_pkg::OP_JP_IMM, cur_addr() + 16'd12);
		emit_long(f8_isa_pkg::OP_LD_DIR_XL, 16'h1502);
		back_to = cur_addr();
		emit_short(f8_isa_pkg::OP_LD_XL_IMM, 8'h22);
		emit_long(f8_isa_pkg::OP_LD_DIR_XL, 16'h1504);
		emit_one(f8_isa_pkg::OP_TRAP);
		emit_long(f8_isa_pkg::OP_LD_DIR_XL, 16'h1506);
		emit_short(f8_isa_pkg::OP_JR_D, 8'(back_to - (cur_addr() + 16'd2)));
		emit_long(f8_isa_pkg::OP_LD_DIR_XL, 16'h1508);
		emit_one(f8_isa_pkg::OP_TRAP);
	endtask

	task automatic build_random_program();
		f8_isa_pkg::opcode_t ops [6];
		int kind;
		logic [7:0] value;
		ops = '{f8_isa_pkg::OP_LD_XL_IMM, f8_isa_pkg::OP_ADD_XL_IMM, f8_isa_pkg::OP_SUB_XL_IMM,
			f8_isa_pkg::OP_AND_XL_IMM, f8_isa_pkg::OP_OR_XL_IMM, f8_isa_pkg::OP_XOR_XL_IMM};
		emit_short(f8_isa_pkg::OP_LD_XL_IMM, 8'($random(seed)));
		for (int i = 0; i < 40; i++)
		begin
			kind = $unsigned($random(seed)) % 8;
			value = 8'($random(seed));
			if (kind < 6)
				emit_short(ops[kind], value);
			else
				emit_long(f8_isa_pkg::OP_LD_DIR_XL, 16'h1600 + 16'(value));
		end
		emit_one(f8_isa_pkg::OP_TRAP);
	endtask

	task automatic load_program();
		for (int i = 0; i < 32768; i++)
			ref_mem[i] = fill_byte(16'(i));
		for (int i = 0; i < prog.size(); i++)
			ref_mem[16'h4000 + i] = prog[i];
		for (int i = 0; i < 16384; i++)
		begin
			even_mem[i] = ref_mem[2 * i];
			odd_mem[i] = ref_mem[2 * i + 1];
		end
	endtask

	task automatic check_first_cycle();
		compare_addr("even_port.rd_addr", even_port.rd_addr,
			f8_bus_pkg::RESET_PC[f8_bus_pkg::ADDR_W-1:1]);
		compare_addr("odd_port.rd_addr", odd_port.rd_addr,
			f8_bus_pkg::RESET_PC[f8_bus_pkg::ADDR_W-1:1]);
		if (even_port.wr_en !== 1'b0 || odd_port.wr_en !== 1'b0)
			report_failure("a bank write enable is high in the first cycle after reset");
		if (trap !== 1'b0)
			report_failure("trap is high in the first cycle after reset");
	endtask

	task automatic run_program();
		cycle_limit += 3 * prog_insts + 10 + 50;
		@(posedge clk);
		reset <= 1'b1;
		trap_seen = 1'b0;
		writes_seen = 0;
		load_program();
		exp_count = run_reference();
		repeat (10) @(posedge clk);
		reset <= 1'b0;
		@(negedge clk);
		check_first_cycle();
		wait (trap_seen);
		repeat (4) @(negedge clk);
		prog.delete();
		prog_insts = 0;
	endtask

	initial
	begin
		reset = 1'b1;
		even_rdata = 8'h00;
		odd_rdata = 8'h00;
		seed = 32'ha49c_367d;
		cycle_count = 0;
		cycle_limit = 0;
		trap_seen = 1'b0;
		writes_seen = 0;
		exp_count = 0;
		prog_insts = 0;
		data_ptr = 16'h1000;
		build_alu_program();
		run_program();
		build_memory_program();
		run_program();
		build_jump_program();
		run_program();
		build_random_program();
		run_program();
		$display("TB PASSED");
		$finish;
	end

endmodule

//--- f8_core.f
hw/f8_isa_pkg.sv
hw/f8_bus_pkg.sv
hw/f8_regfile.sv
hw/f8_sequencer.sv
hw/f8_execute.sv
hw/f8_bus_arbiter.sv
hw/f8_core.sv
verif/f8_core_tb.sv
